//--- sim.f
+incdir+verification
hw/ahb_mem_pkg.sv
hw/ahb_addr_decode.sv
hw/ahb_sram_bank.sv
hw/ahb_resp_mux.sv
hw/ahb_mem_subsys.sv
verification/tb_ahb_mem.sv

//--- verification/ahb_mem_model.svh
`ifndef AHB_MEM_MODEL_SVH
`define AHB_MEM_MODEL_SVH

// ------------------------------
// Reference memory
// ------------------------------
// One word array per bank, same depth as the RTL banks
logic [DATA_W-1:0] model_mem [NUM_BANKS][2**WORD_ADDR_W];

// Region field of an address, upper bits ignored
function automatic int region_of(logic [ADDR_W-1:0] addr);
        return int'(addr[BANK_SEL_LSB +: BANK_SEL_W]);
endfunction

function automatic logic is_mapped(logic [ADDR_W-1:0] addr);
        return (region_of(addr) < NUM_BANKS);
endfunction

function automatic int word_of(logic [ADDR_W-1:0] addr);
        return int'(addr[2 +: WORD_ADDR_W]);    // Word index inside a bank
endfunction

// NONSEQ and SEQ move data, IDLE and BUSY do not
function automatic logic is_active(ahb_req_t r);
        return (r.htrans == NONSEQ) || (r.htrans == SEQ);
endfunction

// Lanes covered by a transfer of 2**size bytes, aligned down
function automatic logic [STRB_W-1:0] lane_mask(hsize_e sz, logic [1:0] off);
        int nbytes;
        int first;
        lane_mask = '0;
        nbytes    = 1 << int'(sz);
        first     = int'(off) & ~(nbytes - 1);
        for (int i = 0; i < nbytes; i++) begin
                if (first + i < STRB_W) begin
                        lane_mask[first + i] = 1'b1;
                end
        end
endfunction

// Old word with the masked lanes replaced
function automatic logic [DATA_W-1:0] merge_lanes(logic [DATA_W-1:0] old_word,
                                                   logic [DATA_W-1:0] new_word,
                                                   logic [STRB_W-1:0] mask);
        logic [DATA_W-1:0] m;
        m = old_word;
        for (int i = 0; i < STRB_W; i++) begin
                if (mask[i]) begin
                        m[8*i +: 8] = new_word[8*i +: 8];
                end
        end
        return m;
endfunction

function automatic void model_write(ahb_req_t r, logic [DATA_W-1:0] wdata);
        int                bank;
        int                word;
        logic [STRB_W-1:0] mask;
        bank = region_of(r.haddr);
        word = word_of(r.haddr);
        mask = lane_mask(r.hsize, r.haddr[1:0]);
        model_mem[bank][word] = merge_lanes(model_mem[bank][word], wdata, mask);
endfunction

// Whole word, whatever the read size
function automatic logic [DATA_W-1:0] model_read(logic [ADDR_W-1:0] addr);
        return model_mem[region_of(addr)][word_of(addr)];
endfunction

// ------------------------------
// Expected response
// ------------------------------
// wait_cnt counts cycles already spent in this data phase
function automatic ahb_rsp_t expect_rsp(ahb_req_t r, int wait_cnt);
        ahb_rsp_t e;
        e        = '0;
        e.hready = 1'b1;                        // Okay, zero wait
        if (is_active(r) && !is_mapped(r.haddr)) begin
                e.hresp  = 1'b1;                // Error in both cycles
                e.hready = (wait_cnt > 0);      // Stall in the first one only
        end
        return e;
endfunction

`endif

//--- verification/tb_ahb_mem.sv
`timescale 1ns/1ps

module tb_ahb_mem import ahb_mem_pkg::*; ();

        localparam int RESET_CYCLES = 8;
        localparam int N_RANDOM     = 400;      // Random transfers after the directed part
        localparam int WIN_WORDS    = 32;       // Words per bank the stimulus touches
        localparam int UPPER_W      = ADDR_W - BANK_SEL_LSB - BANK_SEL_W;

        // One transfer with its address phase and write data
        typedef struct packed {
                ahb_req_t          req;
                logic [DATA_W-1:0] wdata;
        } xfer_t;

        logic              clk;
        logic              RSTn;
        ahb_req_t          req;
        logic [DATA_W-1:0] hwdata;
        ahb_rsp_t          rsp;

        logic [31:0] rng_state = 32'hd26f_b8ba;
        xfer_t       stim_q[$];                 // Transfers in issue order
        int          num_xfers;
        logic        stim_built = 1'b0;

        `include "ahb_mem_model.svh"

        ahb_mem_subsys dut_i (
                .clk    (clk),
                .RSTn   (RSTn),
                .req    (req),
                .hwdata (hwdata),
                .rsp    (rsp)
        );

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;          // 100 MHz
        end

        // ------------------------------
        // Stimulus helpers
        // ------------------------------
        function automatic logic [31:0] next_rand();
                rng_state = rng_state ^ (rng_state << 13);
                rng_state = rng_state ^ (rng_state >> 17);
                rng_state = rng_state ^ (rng_state << 5);
                return rng_state;
        endfunction

        function automatic logic [ADDR_W-1:0] make_addr(int region, int word, int off,
                                                        logic [UPPER_W-1:0] upper);
                logic [ADDR_W-1:0] a;
                a = '0;
                a[BANK_SEL_LSB + BANK_SEL_W +: UPPER_W] = upper;        // Alias bits
                a[BANK_SEL_LSB +: BANK_SEL_W]           = BANK_SEL_W'(region);
                a[2 +: WORD_ADDR_W]                     = WORD_ADDR_W'(word);
                a[1:0]                                  = 2'(off);
                return a;
        endfunction

        // Initial contents depend on every address bit
        function automatic logic [DATA_W-1:0] fill_word(logic [ADDR_W-1:0] a);
                return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
        endfunction

        function automatic xfer_t idle_xfer();
                xfer_t x;
                x            = '0;
                x.req.htrans = IDLE;
                x.req.hsize  = WORD;
                return x;
        endfunction

        task automatic add_xfer(htrans_e tr, logic [ADDR_W-1:0] addr, hsize_e sz, logic wr,
                                logic [DATA_W-1:0] wdata);
                xfer_t x;
                x.req.haddr  = addr;
                x.req.htrans = tr;
                x.req.hsize  = sz;
                x.req.hwrite = wr;
                x.wdata      = wdata;
                stim_q.push_back(x);
        endtask

        task automatic add_write(int region, int word, hsize_e sz, int off);
                logic [UPPER_W-1:0] up;
                logic [DATA_W-1:0]  d;
                up = UPPER_W'(next_rand());
                d  = next_rand();               // Unselected lanes carry noise
                add_xfer(NONSEQ, make_addr(region, word, off, up), sz, 1'b1, d);
        endtask

        task automatic add_read(int region, int word);
                logic [UPPER_W-1:0] up;
                logic [DATA_W-1:0]  noise;
                up    = UPPER_W'(next_rand());
                noise = next_rand();            // Noise on hwdata that a read ignores
                add_xfer(NONSEQ, make_addr(region, word, 0, up), WORD, 1'b0, noise);
        endtask

        task automatic build_stimulus();
                logic [ADDR_W-1:0] a;
                logic [31:0]       r;
                hsize_e            sz;
                htrans_e           tr;
                int                off;
                // Fill the touched window of every bank
                for (int b = 0; b < NUM_BANKS; b++) begin
                        for (int w = 0; w < WIN_WORDS; w++) begin
                                a = make_addr(b, w, 0, UPPER_W'(next_rand()));
                                add_xfer(NONSEQ, a, WORD, 1'b1, fill_word(a));
                        end
                end
                for (int b = 0; b < NUM_BANKS; b++) begin
                        add_write(b, 3, WORD, 0);       // Read follows with no idle
                        add_read(b, 3);
                end
                // Narrow writes followed by whole-word reads
                add_write(0, 5, BYTE, 1);
                add_write(0, 5, BYTE, 3);
                add_write(1, 6, HALF, 2);
                add_read(0, 5);
                add_read(1, 6);
                // Same offset in the other bank stays untouched
                add_write(0, 7, WORD, 0);
                add_read(1, 7);
                add_read(0, 7);
                // Unmapped regions with back-to-back errors
                add_write(2, 7, WORD, 0);
                add_write(3, 9, WORD, 0);
                add_read(2, 7);
                add_read(3, 9);
                add_read(0, 7);
                add_read(1, 9);
                // ------------------------------
                // Random mix
                // ------------------------------
                for (int i = 0; i < N_RANDOM; i++) begin
                        r  = next_rand();
                        tr = (r[2:0] == 3'd0) ? IDLE : NONSEQ;  // About 1 in 8 idle
                        case (r[6:5])
                                2'd0:    sz = BYTE;
                                2'd1:    sz = HALF;
                                default: sz = WORD;
                        endcase
                        if (sz == BYTE) begin
                                off = int'(r[8:7]);
                        end else if (sz == HALF) begin
                                off = int'(r[8]) * 2;
                        end else begin
                                off = 0;
                        end
                        a = make_addr(int'(r[4:3]), int'(r[14:10]), off, UPPER_W'(next_rand()));
                        add_xfer(tr, a, sz, r[9], next_rand());
                end
                // Drain the pipeline
                stim_q.push_back(idle_xfer());
                stim_q.push_back(idle_xfer());
        endtask

        // ------------------------------
        // Checks
        // ------------------------------
        task automatic stop_on_failure();
                $display("STATUS: FAIL");
                $fatal(1, "Stopped at the first failure");
        endtask

        task automatic check_rdata(logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp,
                                   string what);
                if (got !== exp) begin
                        $display("ERROR at %0t ns: %s, expected %h got %h", $time, what, exp, got);
                        stop_on_failure();
                end
        endtask

        task automatic check_rsp(ahb_rsp_t got, ahb_rsp_t exp, string what);
                if ((got.hready !== exp.hready) || (got.hresp !== exp.hresp)) begin
                        $display("ERROR at %0t ns: %s, hready/hresp expected %b/%b got %b/%b",
                                 $time, what, exp.hready, exp.hresp, got.hready, got.hresp);
                        stop_on_failure();
                end
        endtask

        // End of a data phase updates or checks the model
        task automatic finish_xfer(xfer_t x, ahb_rsp_t got);
                if (is_active(x.req) && is_mapped(x.req.haddr)) begin
                        if (x.req.hwrite) begin
                                model_write(x.req, x.wdata);
                        end else begin
                                check_rdata(got.hrdata, model_read(x.req.haddr),
                                            $sformatf("read data at haddr %h", x.req.haddr));
                        end
                end
        endtask

        // ------------------------------
        // Pipelined master
        // ------------------------------
        // One pass per falling edge while rsp is stable
        task automatic run_transfers();
                xfer_t    cur;                  // Address phase on the bus
                xfer_t    slot;                 // Data phase in flight
                ahb_rsp_t got;
                logic     prev_ready;
                logic     done;
                int       wait_cnt;
                int       low_cnt;
                cur        = idle_xfer();       // Driven through reset
                slot       = idle_xfer();
                prev_ready = 1'b1;
                done       = 1'b0;
                wait_cnt   = 0;
                low_cnt    = 0;
                while (!done) begin
                        if (prev_ready) begin   // Address phase taken on the last edge
                                slot     = cur;
                                wait_cnt = 0;
                                if (stim_q.size() == 0) begin
                                        done = 1'b1;
                                end else begin
                                        cur = stim_q.pop_front();
                                end
                        end else begin
                                wait_cnt++;     // Master holds req and hwdata
                        end
                        if (!done) begin
                                got    = rsp;
                                req    = cur.req;
                                hwdata = slot.wdata;
                                check_rsp(got, expect_rsp(slot.req, wait_cnt),
                                          $sformatf("response to haddr %h", slot.req.haddr));
                                if (got.hready) begin
                                        finish_xfer(slot, got);
                                        low_cnt = 0;
                                end else begin
                                        low_cnt++;
                                        if (low_cnt > 2) begin
                                                $display("Bus stuck: hready low for more %s %0t",
                                                         "than two cycles at time", $time);
                                                stop_on_failure();
                                        end
                                end
                                prev_ready = got.hready;
                                @(negedge clk);
                        end
                end
        endtask

        // ------------------------------
        // Main sequence
        // ------------------------------
        initial begin
                ahb_rsp_t okay_rsp;
                okay_rsp        = '0;
                okay_rsp.hready = 1'b1;
                RSTn            = 1'b0;
                req             = '0;           // IDLE
                hwdata          = '0;
                build_stimulus();
                num_xfers  = stim_q.size();
                stim_built = 1'b1;
                repeat (RESET_CYCLES) @(posedge clk);
                @(negedge clk);
                RSTn = 1'b1;
                @(negedge clk);
                check_rsp(rsp, okay_rsp, "first response after reset");
                run_transfers();
                $display("STATUS: PASS");
                $finish;
        end

        // Watchdog allows three cycles per transfer
        initial begin
                wait (stim_built);
                repeat (RESET_CYCLES + num_xfers * 3 + 20) @(posedge clk);
                $display("Timeout: the transfers did not complete in the allowed time");
                $display("STATUS: FAIL");
                $fatal(1, "Watchdog expired");
        end

endmodule

//--- hw/ahb_mem_subsys.sv
`timescale 1ns/1ps

module ahb_mem_subsys import ahb_mem_pkg::*; (
        input  logic              clk,
        input  logic              RSTn,
        input  ahb_req_t          req,          // Master address phase
        input  logic [DATA_W-1:0] hwdata,       // Master data phase
        output ahb_rsp_t          rsp           // Back to the master
);

        // ------------------------------
        // Interconnect
        // ------------------------------
        wire [NUM_BANKS-1:0] hsel;              // One-hot bank select
        data_sel_t           data_sel;          // Current data-phase owner
        wire bank_rdata_array_t bank_rdata;     // One word per bank

        // ------------------------------
        // Address decoder
        // ------------------------------
        ahb_addr_decode decode_i (
                .clk      (clk),
                .RSTn     (RSTn),
                .req      (req),
                .hready   (rsp.hready),         // Bus ready fed back
                .hsel     (hsel),
                .data_sel (data_sel)
        );

        // ------------------------------
        // SRAM banks
        // ------------------------------
        for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
                ahb_sram_bank bank_i (
                        .clk    (clk),
                        .RSTn   (RSTn),
                        .req    (req),
                        .hsel   (hsel[g]),
                        .hready (rsp.hready),
                        .hwdata (hwdata),
                        .rdata  (bank_rdata[g])
                );
        end

        // ------------------------------
        // Response mux
        // ------------------------------
        // Includes the default slave for unmapped regions
        ahb_resp_mux resp_mux_i (
                .clk        (clk),
                .RSTn       (RSTn),
                .data_sel   (data_sel),
                .bank_rdata (bank_rdata),
                .rsp        (rsp)
        );

endmodule

//--- hw/ahb_resp_mux.sv
`timescale 1ns/1ps

module ahb_resp_mux import ahb_mem_pkg::*; (
        input  logic              clk,
        input  logic              RSTn,
        input  data_sel_t         data_sel,     // Data-phase owner from decoder
        input  bank_rdata_array_t bank_rdata,   // Read words of all banks
        output ahb_rsp_t          rsp
);

        // Default slave state
        logic err_first;        // First error cycle stalls
        logic err_second;       // Second error cycle releases

        assign err_first = (data_sel.tgt == TGT_ERR) && !err_second;

        // ------------------------------
        // Error sequencer
        // ------------------------------
        // Two cycles per unmapped transfer and back-to-back errors restart it
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        err_second <= 1'b0;
                end else begin
                        err_second <= err_first;
                end
        end

        // ------------------------------
        // Response
        // ------------------------------
        always_comb begin
                // Okay response by default
                rsp.hready = 1'b1;
                rsp.hresp  = 1'b0;
                rsp.hrdata = '0;

                case (data_sel.tgt)
                        TGT_BANK: begin
                                rsp.hrdata = bank_rdata[data_sel.bank];  // Zero wait
                        end
                        TGT_ERR: begin
                                rsp.hready = !err_first;    // Low only in first cycle
                                rsp.hresp  = 1'b1;          // High in both
                        end
                        default: begin
                                // IDLE or BUSY data phase keeps the okay default
                        end
                endcase
        end

endmodule

//--- hw/ahb_sram_bank.sv
`timescale 1ns/1ps

module ahb_sram_bank import ahb_mem_pkg::*; (
        input  logic              clk,
        input  logic              RSTn,
        input  ahb_req_t          req,
        input  logic              hsel,         // This bank addressed
        input  logic              hready,       // Shared bus ready
        input  logic [DATA_W-1:0] hwdata,       // Data-phase write data
        output logic [DATA_W-1:0] rdata         // Word at registered address
);

        localparam int DEPTH = 2 ** WORD_ADDR_W;

        // ------------------------------
        // Storage
        // ------------------------------
        logic [DATA_W-1:0] mem [DEPTH];

        // Address-phase capture
        logic                   accept;
        logic [WORD_ADDR_W-1:0] word_addr_q;   // Word index in the bank
        hsize_e                 size_q;
        logic [1:0]             offset_q;      // Byte offset in the word
        logic                   wr_pend;       // Write waiting for its data phase

        // Lane enables for the pending write
        logic [STRB_W-1:0]      strb;

        // Transfer is ours and the bus moves on this edge
        assign accept = hsel && hready &&
                        ((req.htrans == NONSEQ) || (req.htrans == SEQ));

        // ------------------------------
        // Address phase registers
        // ------------------------------
        // Address, size and lane offset of the transfer
        always_ff @(posedge clk) begin
                if (accept) begin
                        word_addr_q <= req.haddr[2 +: WORD_ADDR_W];
                        size_q      <= req.hsize;
                        offset_q    <= req.haddr[1:0];
                end
        end

        // Write flag follows the pipeline
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        wr_pend <= 1'b0;
                end else if (hready) begin
                        wr_pend <= accept && req.hwrite;  // Cleared by any other transfer
                end
        end

        // ------------------------------
        // Byte lanes
        // ------------------------------
        always_comb begin
                case (size_q)
                        BYTE:    strb = STRB_W'(1) << offset_q;
                        HALF:    strb = STRB_W'(3) << {offset_q[1], 1'b0};
                        WORD:    strb = '1;
                        default: strb = '1;     // Wider sizes write the full word
                endcase
        end

        // ------------------------------
        // Write port
        // ------------------------------
        // Lands at the end of the data phase
        always_ff @(posedge clk) begin
                if (wr_pend && hready) begin
                        for (int i = 0; i < STRB_W; i++) begin
                                if (strb[i]) begin
                                        mem[word_addr_q][8*i +: 8] <= hwdata[8*i +: 8];
                                end
                        end
                end
        end

        // ------------------------------
        // Read port
        // ------------------------------
        // Asynchronous read for zero wait states
        assign rdata = mem[word_addr_q];

endmodule

//--- hw/ahb_addr_decode.sv
`timescale 1ns/1ps

module ahb_addr_decode import ahb_mem_pkg::*; (
        input  logic                 clk,
        input  logic                 RSTn,
        input  ahb_req_t             req,
        input  logic                 hready,    // Shared bus ready
        output logic [NUM_BANKS-1:0] hsel,      // One-hot, address phase
        output data_sel_t            data_sel   // Registered data-phase owner
);

        logic [BANK_SEL_W-1:0] region;
        logic                  active;
        logic                  mapped;

        // ------------------------------
        // Address phase
        // ------------------------------
        assign region = req.haddr[BANK_SEL_LSB +: BANK_SEL_W];  // Upper bits alias
        assign active = (req.htrans == NONSEQ) || (req.htrans == SEQ);
        assign mapped = (int'(region) < NUM_BANKS);

        // One bank select per mapped region
        always_comb begin
                for (int i = 0; i < NUM_BANKS; i++) begin
                        hsel[i] = (int'(region) == i);
                end
        end

        // ------------------------------
        // Data-phase owner
        // ------------------------------
        // Moves with the pipeline, frozen while a slave stalls
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        data_sel.tgt  <= TGT_NONE;
                        data_sel.bank <= '0;
                end else if (hready) begin
                        if (!active) begin
                                data_sel.tgt <= TGT_NONE;      // IDLE or BUSY
                        end else if (mapped) begin
                                data_sel.tgt <= TGT_BANK;
                        end else begin
                                data_sel.tgt <= TGT_ERR;       // Regions 2 and 3
                        end
                        data_sel.bank <= bank_idx_t'(region);  // Only used for TGT_BANK
                end
        end

endmodule

//--- hw/ahb_mem_pkg.sv
package ahb_mem_pkg;

        // ------------------------------
        // Bus widths
        // ------------------------------
        localparam int ADDR_W = 32;             // HADDR width
        localparam int DATA_W = 32;             // HRDATA / HWDATA width
        localparam int STRB_W = DATA_W / 8;     // Byte lanes per word

        // ------------------------------
        // Memory map
        // ------------------------------
        localparam int NUM_BANKS    = 2;        // SRAM banks on the bus
        localparam int WORD_ADDR_W  = 10;       // 1024 words, 4 KB per bank
        localparam int BANK_SEL_LSB = 12;       // Region field starts here
        localparam int BANK_SEL_W   = 2;        // Regions 0..3, upper two unmapped

        // ------------------------------
        // AHB-lite encodings
        // ------------------------------
        typedef enum logic [1:0] {
                IDLE   = 2'b00,
                BUSY   = 2'b01,
                NONSEQ = 2'b10,
                SEQ    = 2'b11
        } htrans_e;

        typedef enum logic [2:0] {
                BYTE = 3'b000,
                HALF = 3'b001,
                WORD = 3'b010
        } hsize_e;

        // Address-phase signals from the master
        typedef struct packed {
                logic [ADDR_W-1:0] haddr;
                htrans_e           htrans;
                hsize_e            hsize;
                logic              hwrite;
        } ahb_req_t;

        // Response back to the master
        typedef struct packed {
                logic [DATA_W-1:0] hrdata;
                logic              hready;
                logic              hresp;  // 1 = ERROR
        } ahb_rsp_t;

        // ------------------------------
        // Internal routing
        // ------------------------------
        typedef logic [$clog2(NUM_BANKS)-1:0] bank_idx_t;

        typedef enum logic [1:0] {
                TGT_NONE = 2'b00,               // Idle data phase
                TGT_BANK = 2'b01,               // One of the SRAM banks
                TGT_ERR  = 2'b10                // Default slave
        } target_e;

        // Owner of the current data phase
        typedef struct packed {
                target_e   tgt;
                bank_idx_t bank;
        } data_sel_t;

        typedef logic [NUM_BANKS-1:0][DATA_W-1:0] bank_rdata_array_t;

endpackage
